// File: all.f
+incdir+.
ec_pkg.sv
ec_input_stage.sv
ec_lut_offsets.sv
stage_1.sv
ec_range_update.sv
ec_output_stage.sv
ec_encoder_top.sv
tb_ec_encoder.sv

// File: ec_defines.svh
`ifndef EC_DEFINES_SVH
`define EC_DEFINES_SVH

// range coder widths.
`define EC_RANGE_W     16     // range and frequency bounds.
`define EC_SYM_W       4      // symbol index, 0 to 15.
`define EC_NSYM_W      5      // symbol count, holds 16.
`define EC_LUT_AW      8      // offset table address, {n, symbol}.
`define EC_LUT_DW      16     // offset table data.
`define EC_LOW_W       32     // low word, wraps without carry.

`define EC_RANGE_INIT  32768  // range after reset.

`endif

// File: ec_encoder_top.sv
`timescale 1ns/10ps

module ec_encoder_top (
  input  logic               clk,
  input  logic               reset,
  input  logic               in_valid,
  input  ec_pkg::ec_req_t    in_req,
  output logic               in_ready,
  output logic               out_valid,
  output ec_pkg::ec_result_t out_res,
  input  logic               out_ready
);

  logic               req_valid;  // input stage to stage one.
  logic               req_ready;
  ec_pkg::ec_req_t    req;
  logic               s1_valid;   // stage one to range update.
  logic               s1_ready;
  ec_pkg::ec_stage1_t s1;
  logic               res_valid;  // range update to output buffer.
  logic               res_ready;
  ec_pkg::ec_result_t res;

  ec_input_stage ec_input_stage_inst (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .in_req   (in_req),
    .in_ready (in_ready),
    .s_valid  (req_valid),
    .s_req    (req),
    .s_ready  (req_ready)
  );

  stage_1 stage_1_inst (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (req_valid),
    .in_req    (req),
    .in_ready  (req_ready),
    .out_valid (s1_valid),
    .out_s1    (s1),
    .out_ready (s1_ready)
  );

  ec_range_update ec_range_update_inst (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (s1_valid),
    .in_s1     (s1),
    .in_ready  (s1_ready),
    .out_valid (res_valid),
    .out_res   (res),
    .out_ready (res_ready)
  );

  ec_output_stage ec_output_stage_inst (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (res_valid),
    .in_res    (res),
    .in_ready  (res_ready),
    .out_valid (out_valid),
    .out_res   (out_res),
    .out_ready (out_ready)
  );

endmodule

// File: ec_input_stage.sv
`timescale 1ns/10ps

module ec_input_stage (
  input  logic            clk,
  input  logic            reset,
  input  logic            in_valid,
  input  ec_pkg::ec_req_t in_req,
  output logic            in_ready,
  output logic            s_valid,
  output ec_pkg::ec_req_t s_req,
  input  logic            s_ready
);

  logic accept; // request taken this cycle.

  // free when empty or when stage one drains us now.
  assign in_ready = !s_valid || s_ready;
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      s_valid <= 1'b0;
    end else if (accept) begin
      s_valid <= 1'b1;
    end else if (s_ready) begin
      s_valid <= 1'b0; // taken, nothing new behind it.
    end
  end

  // payload only moves on accept, so it holds while stalled.
  always_ff @(posedge clk) begin
    if (accept) begin
      s_req <= in_req;
    end
  end

endmodule

// File: ec_lut_offsets.sv
`timescale 1ns/10ps
`include "ec_defines.svh"

module ec_lut_offsets (
  input  logic [`EC_LUT_AW-1:0] addr,
  output logic [`EC_LUT_DW-1:0] u_off,
  output logic [`EC_LUT_DW-1:0] v_off
);

  logic [`EC_SYM_W-1:0] n;     // highest symbol index, nsyms - 1.
  logic [`EC_SYM_W-1:0] s;     // coded symbol.
  logic [`EC_SYM_W:0]   rem_v; // symbols above s.
  logic [`EC_SYM_W:0]   rem_u; // symbols from s upward.

  assign n = addr[`EC_LUT_AW-1:`EC_SYM_W];
  assign s = addr[`EC_SYM_W-1:0];

  // one extra bit so n - s + 1 can reach 16.
  assign rem_v = {1'b0, n} - {1'b0, s};
  assign rem_u = rem_v + 1'b1;

  always_comb begin
    if (s > n) begin
      u_off = '0; // symbol outside the alphabet.
      v_off = '0;
    end else begin
      // four per remaining symbol.
      u_off = {{(`EC_LUT_DW-`EC_SYM_W-3){1'b0}}, rem_u, 2'b00};
      v_off = {{(`EC_LUT_DW-`EC_SYM_W-3){1'b0}}, rem_v, 2'b00};
    end
  end

endmodule

// File: ec_output_stage.sv
`timescale 1ns/10ps
`include "ec_defines.svh"

module ec_output_stage (
  input  logic               clk,
  input  logic               reset,
  input  logic               in_valid,
  input  ec_pkg::ec_result_t in_res,
  output logic               in_ready,
  output logic               out_valid,
  output ec_pkg::ec_result_t out_res,
  input  logic               out_ready
);

  ec_pkg::ec_buf_state_e state_q; // entries held.
  ec_pkg::ec_result_t    tail_q;  // second entry, skid slot.
  ec_pkg::ec_result_t    rec;     // incoming record with total.
  logic [`EC_LOW_W-1:0]  total_q; // shifts accepted so far.
  logic                  push;
  logic                  pop;

  // both come straight off state_q, so out_ready never reaches in_ready.
  assign out_valid = (state_q != ec_pkg::BUF_EMPTY);
  assign in_ready  = (state_q != ec_pkg::BUF_TWO);

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_comb begin
    rec            = in_res;
    rec.total_bits = total_q + in_res.shift; // includes this symbol.
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ec_pkg::BUF_EMPTY;
      total_q <= '0;
    end else begin
      if (push) begin
        total_q <= rec.total_bits;
      end
      case (state_q)
        ec_pkg::BUF_EMPTY: if (push) state_q <= ec_pkg::BUF_ONE;
        ec_pkg::BUF_ONE: begin
          if (push && !pop) begin
            state_q <= ec_pkg::BUF_TWO;
          end else if (!push && pop) begin
            state_q <= ec_pkg::BUF_EMPTY;
          end
        end
        ec_pkg::BUF_TWO:   if (pop) state_q <= ec_pkg::BUF_ONE;
        default:           state_q <= ec_pkg::BUF_EMPTY;
      endcase
    end
  end

  // head is out_res, tail catches what arrives while head waits.
  always_ff @(posedge clk) begin
    case (state_q)
      ec_pkg::BUF_EMPTY: if (push) out_res <= rec;
      ec_pkg::BUF_ONE: begin
        if (push && pop) begin
          out_res <= rec;  // pass through.
        end else if (push) begin
          tail_q <= rec;   // head stalled.
        end
      end
      ec_pkg::BUF_TWO:   if (pop) out_res <= tail_q;
      default: ;
    endcase
  end

endmodule

// File: ec_pkg.sv
`include "ec_defines.svh"

package ec_pkg;

  // one symbol to encode.
  typedef struct packed {
    logic [`EC_RANGE_W-1:0] fl;      // low cumulative bound.
    logic [`EC_RANGE_W-1:0] fh;      // high cumulative bound.
    logic [`EC_SYM_W-1:0]   symbol;  // symbol index.
    logic [`EC_NSYM_W-1:0]  nsyms;   // symbols in the alphabet.
    logic                   is_bool; // table addressed as two symbols.
  } ec_req_t;

  // prescaled bounds and table offsets out of stage one.
  typedef struct packed {
    logic [`EC_RANGE_W-1:0] uu;         // fl >> 6.
    logic [`EC_RANGE_W-1:0] vv;         // fh >> 6.
    logic [`EC_LUT_DW-1:0]  lut_u;      // offset added to u.
    logic [`EC_LUT_DW-1:0]  lut_v;      // offset added to v.
    logic                   lower_half; // fl below half range.
  } ec_stage1_t;

  // Result of one coded symbol, after renormalization.
  typedef struct packed {
    logic [`EC_RANGE_W-1:0] rng;        // normalized range.
    logic [`EC_LOW_W-1:0]   low;        // low word after shift.
    logic [`EC_SYM_W-1:0]   shift;      // renormalization shift.
    logic [`EC_LOW_W-1:0]   total_bits; // running sum of shifts.
  } ec_result_t;

  // fill level of the output skid buffer.
  typedef enum logic [1:0] {
    BUF_EMPTY = 2'd0,
    BUF_ONE   = 2'd1,
    BUF_TWO   = 2'd2
  } ec_buf_state_e;

endpackage

// File: ec_range_update.sv
`timescale 1ns/10ps
`include "ec_defines.svh"

module ec_range_update (
  input  logic               clk,
  input  logic               reset,
  input  logic               in_valid,
  input  ec_pkg::ec_stage1_t in_s1,
  output logic               in_ready,
  output logic               out_valid,
  output ec_pkg::ec_result_t out_res,
  input  logic               out_ready
);

  logic [`EC_RANGE_W-1:0] rng_q;     // coder range state.
  logic [`EC_LOW_W-1:0]   low_q;     // coder low state.
  logic [`EC_RANGE_W-9:0] q;         // range >> 8.
  logic [`EC_RANGE_W+7:0] prod_u;    // q * uu.
  logic [`EC_RANGE_W+7:0] prod_v;    // q * vv.
  logic [`EC_RANGE_W:0]   u_val;     // scaled low bound plus offset.
  logic [`EC_RANGE_W:0]   v_val;     // scaled high bound plus offset.
  logic [`EC_RANGE_W:0]   rng_diff;  // new range before truncation.
  logic [`EC_RANGE_W:0]   low_add;   // r - u.
  logic [`EC_RANGE_W-1:0] rng_new;
  logic [`EC_LOW_W-1:0]   low_new;
  logic [`EC_SYM_W-1:0]   msb;       // top set bit of rng_new.
  logic [`EC_SYM_W-1:0]   d;         // renormalization shift.
  logic [`EC_RANGE_W-1:0] rng_norm;
  logic [`EC_LOW_W-1:0]   low_norm;
  logic                   accept;

  assign q      = rng_q[`EC_RANGE_W-1:8];
  assign prod_u = q * in_s1.uu;
  assign prod_v = q * in_s1.vv;
  assign u_val  = prod_u[`EC_RANGE_W+1:1] + in_s1.lut_u; // (q*uu >> 1) + offset.
  assign v_val  = prod_v[`EC_RANGE_W+1:1] + in_s1.lut_v;

  // interval update.
  assign low_add  = {1'b0, rng_q} - u_val;
  assign rng_diff = in_s1.lower_half ? (u_val - v_val) : ({1'b0, rng_q} - v_val);
  assign rng_new  = rng_diff[`EC_RANGE_W-1:0];
  assign low_new  = in_s1.lower_half ?
                    low_q + {{(`EC_LOW_W-`EC_RANGE_W-1){1'b0}}, low_add} : low_q;

  // priority encode, last hit is the highest bit.
  always_comb begin
    msb = '0;
    for (int i = 0; i < `EC_RANGE_W; i++) begin
      if (rng_new[i]) begin
        msb = i[`EC_SYM_W-1:0];
      end
    end
  end

  assign d        = 4'd15 - msb;
  assign rng_norm = rng_new << d;   // top bit back at 15.
  assign low_norm = low_new << d;   // wraps, no carry out.

  assign in_ready = !out_valid || out_ready;
  assign accept   = in_valid && in_ready;

  // state closes the loop in one cycle, back-to-back safe.
  always_ff @(posedge clk) begin
    if (reset) begin
      rng_q     <= `EC_RANGE_INIT;
      low_q     <= '0;
      out_valid <= 1'b0;
    end else begin
      if (accept) begin
        rng_q <= rng_norm;
        low_q <= low_norm;
      end
      if (accept) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_res.rng        <= rng_norm;
      out_res.low        <= low_norm;
      out_res.shift      <= d;
      out_res.total_bits <= '0; // summed in the output stage.
    end
  end

endmodule

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_ec_encoder -f all.f \
  && ./obj_dir/Vtb_ec_encoder > sim.log 2>&1 \
  && cat sim.log \
  && ! grep -q "TESTBENCH FAILED" sim.log \
  || { echo "simulation failed"; exit 1; }

// File: stage_1.sv
`timescale 1ns/10ps
`include "ec_defines.svh"

module stage_1 (
  input  logic               clk,
  input  logic               reset,
  input  logic               in_valid,
  input  ec_pkg::ec_req_t    in_req,
  output logic               in_ready,
  output logic               out_valid,
  output ec_pkg::ec_stage1_t out_s1,
  input  logic               out_ready
);

  logic [`EC_NSYM_W-1:0] n_full;   // nsyms - 1, full width.
  logic [`EC_SYM_W-1:0]  n_eff;    // table row actually used.
  logic [`EC_LUT_AW-1:0] lut_addr; // {row, symbol}.
  logic [`EC_LUT_DW-1:0] lut_u;
  logic [`EC_LUT_DW-1:0] lut_v;
  logic                  accept;

  assign n_full = in_req.nsyms - 1'b1;
  // bool symbols always use the two-symbol row.
  assign n_eff    = in_req.is_bool ? {{(`EC_SYM_W-1){1'b0}}, 1'b1} :
                                     n_full[`EC_SYM_W-1:0];
  assign lut_addr = {n_eff, in_req.symbol};

  ec_lut_offsets ec_lut_offsets_inst (
    .addr  (lut_addr),
    .u_off (lut_u),
    .v_off (lut_v)
  );

  assign in_ready = !out_valid || out_ready;
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_s1.uu         <= in_req.fl >> 6;   // prescale to 10 bits.
      out_s1.vv         <= in_req.fh >> 6;
      out_s1.lut_u      <= lut_u;
      out_s1.lut_v      <= lut_v;
      out_s1.lower_half <= !in_req.fl[`EC_RANGE_W-1]; // fl < 32768.
    end
  end

endmodule

// File: tb_ec_encoder.sv
`timescale 1ns/10ps
`include "ec_defines.svh"

module tb_ec_encoder;

  localparam int MAX_CYCLES = 2000; // all tests need well under 700 cycles.

  logic               clk = 1'b0;
  logic               reset;
  logic               in_valid;
  ec_pkg::ec_req_t    in_req;
  logic               in_ready;
  logic               out_valid;
  ec_pkg::ec_result_t out_res;
  logic               out_ready = 1'b1;
  logic               toggle_ready = 1'b0; // random out_ready while set.

  ec_pkg::ec_result_t exp_q[$];  // expected records, oldest first.
  ec_pkg::ec_result_t exp_rec;
  int                 m_rng;     // shadow coder range.
  logic [31:0]        m_low;     // shadow low word.
  logic [31:0]        m_total;   // shadow shift total.
  logic [31:0]        stim_seed = 32'd47855;
  logic [31:0]        ready_seed = 32'd47855;
  int                 err_cnt, chk_cnt, rec_cnt, cycle_cnt;
  int                 err_base, rec_base; // counts at the start of a test.

  ec_encoder_top ec_encoder_top_inst (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_res   (out_res),
    .out_ready (out_ready)
  );

  always #10 clk = ~clk; // 20 ns period.

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the run hung waiting on the DUT", cycle_cnt);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // back-pressure source, held high unless toggling.
  always @(posedge clk) begin
    ready_seed = lcg_step(ready_seed);
    out_ready <= !toggle_ready || ready_seed[20];
  end

  // outputs are stable at negedge, the transfer lands on the next posedge.
  always @(negedge clk) begin
    if (!reset && out_valid && out_ready) begin
      rec_cnt++;
      assert (exp_q.size() != 0) else begin
        $display("unexpected output record, no request is outstanding");
        err_cnt++;
      end
      if (exp_q.size() != 0) begin
        exp_rec = exp_q.pop_front();
        compare_field("rng", 32'(exp_rec.rng), 32'(out_res.rng));
        compare_field("low", exp_rec.low, out_res.low);
        compare_field("shift", 32'(exp_rec.shift), 32'(out_res.shift));
        compare_field("total_bits", exp_rec.total_bits, out_res.total_bits);
      end
    end
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic int next_rand();
    stim_seed = lcg_step(stim_seed);
    return int'(stim_seed[30:16]); // upper bits, low ones cycle fast.
  endfunction

  function automatic ec_pkg::ec_req_t make_random_req();
    ec_pkg::ec_req_t r;
    int top;
    r        = '0;
    r.nsyms  = 5'(2 + next_rand() % 15);          // 2 to 16 symbols.
    r.symbol = 4'(next_rand() % int'(r.nsyms));
    r.fl     = (r.symbol == 0) ? 16'd32768 : 16'(1000 + next_rand() % 29000);
    top      = r.fl[15] ? 30000 : int'(r.fl);
    r.fh     = 16'(next_rand() % (top - 64));     // fh stays below fl.
    return r;
  endfunction

  // reference model, run once per accepted request.
  task automatic predict(input ec_pkg::ec_req_t r);
    int n, s, lut_u, lut_v;
    int q, u, v, rng, d;
    ec_pkg::ec_result_t e;
    n     = r.is_bool ? 1 : ((int'(r.nsyms) - 1) & 15);
    s     = int'(r.symbol);
    lut_u = (s > n) ? 0 : 4 * (n - s + 1);
    lut_v = (s > n) ? 0 : 4 * (n - s);
    q     = m_rng / 256;
    u     = (q * int'(r.fl / 64)) / 2 + lut_u;
    v     = (q * int'(r.fh / 64)) / 2 + lut_v;
    if (r.fl < 16'd32768) begin
      m_low = m_low + 32'(m_rng - u);
      rng   = u - v;
    end else begin
      rng = m_rng - v;
    end
    rng = rng & 32'hffff;
    d   = 0;
    while (d < 15 && rng < (32'h8000 >> d)) d++;  // bring the top bit to 15.
    m_rng        = (rng << d) & 32'hffff;
    m_low        = m_low << d;
    m_total      = m_total + 32'(d);
    e.rng        = 16'(m_rng);
    e.low        = m_low;
    e.shift      = 4'(d);
    e.total_bits = m_total;
    exp_q.push_back(e);
  endtask

  task automatic compare_field(input string name, input logic [31:0] expv,
                               input logic [31:0] gotv);
    chk_cnt++;
    assert (gotv == expv) else begin
      $display("ERR %s expected %h got %h", name, expv, gotv);
      err_cnt++;
    end
  endtask

  // called on a posedge, returns on the edge that took the request.
  task automatic send_req(input ec_pkg::ec_req_t r);
    logic taken;
    in_valid <= 1'b1;
    in_req   <= r;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = in_ready;
      @(posedge clk);
    end
    predict(r);
  endtask

  task automatic wait_drain();
    in_valid <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    repeat (3) @(posedge clk); // room for a stray extra record.
  endtask

  task automatic end_test(input string name, input int n_req);
    assert (rec_cnt - rec_base == n_req) else begin
      $display("%s: %0d records came out for %0d requests", name, rec_cnt - rec_base, n_req);
      err_cnt++;
    end
    $display("test %s finished, %0d errors", name, err_cnt - err_base);
    err_base = err_cnt;
    rec_base = rec_cnt;
  endtask

  task automatic after_reset_symbol();
    send_req('{fl: 16'd32768, fh: 16'd20000, symbol: 4'd0, nsyms: 5'd16, is_bool: 1'b0});
    wait_drain();
    end_test("after_reset", 1);
  endtask

  task automatic lower_half_sweep();
    ec_pkg::ec_req_t r;
    for (int i = 0; i < 5; i++) begin
      r = '{fl: 16'(24000 - 2000 * i), fh: 16'(19000 - 2000 * i), symbol: 4'(1 + 3 * i),
            nsyms: 5'(2 + 3 * i), is_bool: 1'b0}; // last symbol of the alphabet.
      send_req(r);
      r.symbol = 4'(i);
      send_req(r);
    end
    // symbol past the alphabet, zero offsets.
    send_req('{fl: 16'd20000, fh: 16'd10000, symbol: 4'd9, nsyms: 5'd4, is_bool: 1'b0});
    wait_drain();
    end_test("lower_half", 11);
  endtask

  task automatic bool_mode_rows();
    ec_pkg::ec_req_t r;
    for (int i = 0; i < 10; i++) begin
      r.nsyms   = 5'(next_rand()); // ignored, row two is forced.
      r.is_bool = 1'b1;
      r.symbol  = 4'(i % 2);
      r.fl      = (i % 2 == 0) ? 16'd32768 : 16'(8000 + next_rand() % 20000);
      r.fh      = 16'(next_rand() % 7000);
      send_req(r);
    end
    wait_drain();
    end_test("bool_mode", 10);
  endtask

  task automatic random_stream();
    for (int i = 0; i < 200; i++) send_req(make_random_req());
    wait_drain();
    end_test("random_stream", 200);
  endtask

  task automatic backpressure_stream();
    toggle_ready <= 1'b1;
    for (int i = 0; i < 120; i++) send_req(make_random_req());
    toggle_ready <= 1'b0;
    wait_drain();
    end_test("backpressure", 120);
  endtask

  task automatic minimum_range();
    // fl equal to fh leaves only the offset step of 4.
    send_req('{fl: 16'd16384, fh: 16'd16384, symbol: 4'd0, nsyms: 5'd16, is_bool: 1'b0});
    send_req('{fl: 16'd32768, fh: 16'd32767, symbol: 4'd0, nsyms: 5'd16, is_bool: 1'b0});
    wait_drain();
    end_test("minimum_range", 2);
  endtask

  initial begin
    reset    = 1'b1;
    in_valid = 1'b0;
    in_req   = '0;
    m_rng    = `EC_RANGE_INIT;
    m_low    = '0;
    m_total  = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    after_reset_symbol();
    lower_half_sweep();
    bool_mode_rows();
    random_stream();
    backpressure_stream();
    minimum_range();
    $display("checks %0d, records %0d, errors %0d", chk_cnt, rec_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
